//--- design/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  // Word width used when the top level is not overridden.
  localparam int DATA_WIDTH_DEFAULT = 32;

  // Architectural register count, fixed by the 4-bit register fields.
  localparam int NUM_REGS = 16;

  // Width of a register index.
  localparam int REG_ADDR_W = $clog2(NUM_REGS);

endpackage

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Instruction word size.
  localparam int INSTR_W = 32;

  // Opcode field width.
  localparam int OPC_W = 4;

  // Low bit of each field within the instruction word.
  localparam int OPC_LSB = 28;  // Bits 31..28.
  localparam int RD_LSB  = 24;  // Bits 27..24.
  localparam int RS1_LSB = 20;  // Bits 23..20.
  localparam int RS2_LSB = 16;  // Bits 19..16.

  // Immediate occupies bits 15..0 and is sign-extended.
  localparam int IMM_W = 16;

  // Codes 10 to 15 are not assigned and never write back.
  typedef enum logic [OPC_W-1:0] {
    OP_ADD  = 4'd0,  // rs1 + rs2.
    OP_SUB  = 4'd1,  // rs1 - rs2.
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,  // Shift by low 5 bits of rs2.
    OP_SRL  = 4'd6,
    OP_SLT  = 4'd7,  // Signed compare, 1 or 0.
    OP_ADDI = 4'd8,  // rs1 + imm.
    OP_LUI  = 4'd9   // imm << 16.
  } opcode_t;

endpackage

`default_nettype wire

//--- design/issue_if.sv
`timescale 1ns/1ns
`default_nettype none

// One decoded instruction, valid for a single cycle.
interface issue_if #(
  parameter int DATA_WIDTH = core_cfg_pkg::DATA_WIDTH_DEFAULT
) ();

  logic                                valid;  // One-cycle strobe.
  isa_pkg::opcode_t                    op;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2;
  logic [DATA_WIDTH-1:0]               imm;    // Already sign-extended.

  modport decode (
    output valid, op, rd, rs1, rs2, imm
  );

  // Register file only needs the source indices.
  modport reader (
    input rs1, rs2
  );

  modport exec (
    input valid, op, rd, imm
  );

endinterface

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode #(
  parameter int DATA_WIDTH = core_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input  logic                        instr_valid,
  input  logic [isa_pkg::INSTR_W-1:0] instr,
  issue_if.decode                     issue
);

  logic [isa_pkg::OPC_W-1:0] opc_field;
  isa_pkg::opcode_t          op;
  logic                      op_defined;
  logic [isa_pkg::IMM_W-1:0] imm_field;

  assign opc_field = instr[isa_pkg::OPC_LSB +: isa_pkg::OPC_W];
  assign op        = isa_pkg::opcode_t'(opc_field);
  assign imm_field = instr[isa_pkg::IMM_W-1:0];

  // Flag codes outside the opcode table.
  always_comb begin
    case (op)
      isa_pkg::OP_ADD,
      isa_pkg::OP_SUB,
      isa_pkg::OP_AND,
      isa_pkg::OP_OR,
      isa_pkg::OP_XOR,
      isa_pkg::OP_SLL,
      isa_pkg::OP_SRL,
      isa_pkg::OP_SLT,
      isa_pkg::OP_ADDI,
      isa_pkg::OP_LUI: op_defined = 1'b1;
      default:         op_defined = 1'b0;
    endcase
  end

  // Undefined instructions are dropped here.
  assign issue.valid = instr_valid && op_defined;
  assign issue.op    = op;

  assign issue.rd  = instr[isa_pkg::RD_LSB  +: core_cfg_pkg::REG_ADDR_W];
  assign issue.rs1 = instr[isa_pkg::RS1_LSB +: core_cfg_pkg::REG_ADDR_W];
  assign issue.rs2 = instr[isa_pkg::RS2_LSB +: core_cfg_pkg::REG_ADDR_W];

  // Sign-extend to the datapath width.
  assign issue.imm = {{(DATA_WIDTH - isa_pkg::IMM_W){imm_field[isa_pkg::IMM_W-1]}},
                      imm_field};

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file #(
  parameter int DATA_WIDTH = core_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input  logic                                clk,

  // Port A, execute write-back.
  input  logic                                wb_valid,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [DATA_WIDTH-1:0]               wb_data,

  // Port B, load return.
  input  logic                                load_valid,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] load_rd,
  input  logic [DATA_WIDTH-1:0]               load_data,

  issue_if.reader                             rd_req,
  output logic [DATA_WIDTH-1:0]               rs1_data,
  output logic [DATA_WIDTH-1:0]               rs2_data
);

  logic [DATA_WIDTH-1:0] regs [core_cfg_pkg::NUM_REGS];

  logic load_collides;  // Both ports aim at one register.

  assign load_collides = wb_valid && (load_rd == wb_rd);

  // Port A has priority, the colliding load is lost.
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      regs[wb_rd] <= wb_data;
    end
    if (load_valid && !load_collides) begin
      regs[load_rd] <= load_data;
    end
  end

  // A write in this cycle is seen by a read of the same register.
  function automatic logic [DATA_WIDTH-1:0] bypass_read(
    input logic [core_cfg_pkg::REG_ADDR_W-1:0] addr
  );
    logic [DATA_WIDTH-1:0] value;
    if (wb_valid && (wb_rd == addr)) begin
      value = wb_data;
    end else if (load_valid && (load_rd == addr)) begin
      value = load_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = bypass_read(rd_req.rs1);
    rs2_data = bypass_read(rd_req.rs2);
  end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage #(
  parameter int DATA_WIDTH = core_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input  logic                                clk,
  input  logic                                reset,

  issue_if.exec                               issue,
  input  logic [DATA_WIDTH-1:0]               rs1_data,
  input  logic [DATA_WIDTH-1:0]               rs2_data,

  output logic                                wb_valid,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_WIDTH-1:0]               wb_data
);

  logic [DATA_WIDTH-1:0] opnd_a;
  logic [DATA_WIDTH-1:0] opnd_b;
  logic [4:0]            shamt;
  logic                  use_imm;
  logic [DATA_WIDTH-1:0] result;

  // Immediate forms replace rs2.
  assign use_imm = (issue.op == isa_pkg::OP_ADDI) || (issue.op == isa_pkg::OP_LUI);

  assign opnd_a = rs1_data;
  assign opnd_b = use_imm ? issue.imm : rs2_data;
  assign shamt  = opnd_b[4:0];  // Low 5 bits only, even at 64.

  always_comb begin
    case (issue.op)
      isa_pkg::OP_ADD:  result = opnd_a + opnd_b;
      isa_pkg::OP_SUB:  result = opnd_a - opnd_b;
      isa_pkg::OP_AND:  result = opnd_a & opnd_b;
      isa_pkg::OP_OR:   result = opnd_a | opnd_b;
      isa_pkg::OP_XOR:  result = opnd_a ^ opnd_b;
      isa_pkg::OP_SLL:  result = opnd_a << shamt;
      isa_pkg::OP_SRL:  result = opnd_a >> shamt;
      isa_pkg::OP_SLT: begin
        result    = '0;
        result[0] = $signed(opnd_a) < $signed(opnd_b);
      end
      isa_pkg::OP_ADDI: result = opnd_a + opnd_b;
      isa_pkg::OP_LUI:  result = opnd_b << isa_pkg::IMM_W;
      default:          result = '0;  // Never issued.
    endcase
  end

  // Write-back is presented for the whole next cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= issue.rd;
    wb_data <= result;
  end

endmodule

`default_nettype wire

//--- design/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core #(
  parameter int DATA_WIDTH = core_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input  logic                                clk,
  input  logic                                reset,

  // Instruction stream.
  input  logic                                instr_valid,
  input  logic [isa_pkg::INSTR_W-1:0]         instr,

  // Load data returned by the memory system.
  input  logic                                load_valid,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] load_rd,
  input  logic [DATA_WIDTH-1:0]               load_data,

  // Execute results, also fed back to port A.
  output logic                                wb_valid,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_WIDTH-1:0]               wb_data
);

  logic [DATA_WIDTH-1:0] rs1_data;
  logic [DATA_WIDTH-1:0] rs2_data;

  issue_if #(.DATA_WIDTH(DATA_WIDTH)) issue_bus ();

  instr_decode #(
    .DATA_WIDTH (DATA_WIDTH)
  ) instr_decode_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .issue       (issue_bus.decode)
  );

  register_file #(
    .DATA_WIDTH (DATA_WIDTH)
  ) register_file_i (
    .clk        (clk),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .load_valid (load_valid),
    .load_rd    (load_rd),
    .load_data  (load_data),
    .rd_req     (issue_bus.reader),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

  execute_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) execute_stage_i (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue_bus.exec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire

//--- verif/exec_core_model.svh
`ifndef EXEC_CORE_MODEL_SVH
`define EXEC_CORE_MODEL_SVH

// Shadow copy of the architectural registers.
logic [DATA_WIDTH-1:0]               shadow_regs [core_cfg_pkg::NUM_REGS];

// Write-back that the DUT must present in the current cycle.
logic                                pend_valid = 1'b0;
logic [core_cfg_pkg::REG_ADDR_W-1:0] pend_rd    = '0;
logic [DATA_WIDTH-1:0]               pend_data  = '0;

function automatic logic [DATA_WIDTH-1:0] op_result(
  input isa_pkg::opcode_t      op,
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b
);
  logic [DATA_WIDTH-1:0] r;
  r = '0;
  case (op)
    isa_pkg::OP_ADD:  r = a + b;
    isa_pkg::OP_ADDI: r = a + b;  // b is the extended immediate.
    isa_pkg::OP_SUB:  r = a - b;
    isa_pkg::OP_AND:  r = a & b;
    isa_pkg::OP_OR:   r = a | b;
    isa_pkg::OP_XOR:  r = a ^ b;
    isa_pkg::OP_SLL:  r = a << b[4:0];
    isa_pkg::OP_SRL:  r = a >> b[4:0];
    isa_pkg::OP_SLT: begin
      if ($signed(a) < $signed(b)) begin
        r = 1;
      end
    end
    isa_pkg::OP_LUI:  r = b << 16;
    default:          r = '0;
  endcase
  return r;
endfunction

// Operand seen in a cycle, with the write-back ahead of the load.
function automatic logic [DATA_WIDTH-1:0] model_read(
  input logic [core_cfg_pkg::REG_ADDR_W-1:0] addr,
  input logic                                ld_valid,
  input logic [core_cfg_pkg::REG_ADDR_W-1:0] ld_rd,
  input logic [DATA_WIDTH-1:0]               ld_data
);
  if (pend_valid && (pend_rd == addr)) begin
    return pend_data;
  end
  if (ld_valid && (ld_rd == addr)) begin
    return ld_data;
  end
  return shadow_regs[addr];
endfunction

// Advances the model by one cycle of issue and register writes.
task automatic model_step(
  input logic                                valid_in,
  input logic [isa_pkg::INSTR_W-1:0]         word,
  input logic                                ld_valid,
  input logic [core_cfg_pkg::REG_ADDR_W-1:0] ld_rd,
  input logic [DATA_WIDTH-1:0]               ld_data
);
  isa_pkg::opcode_t                    op;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2;
  logic [DATA_WIDTH-1:0]               imm;
  logic [DATA_WIDTH-1:0]               a;
  logic [DATA_WIDTH-1:0]               b;
  logic                                defined;
  op      = isa_pkg::opcode_t'(word[isa_pkg::OPC_LSB +: 4]);
  rd      = word[isa_pkg::RD_LSB +: core_cfg_pkg::REG_ADDR_W];
  rs1     = word[isa_pkg::RS1_LSB +: core_cfg_pkg::REG_ADDR_W];
  rs2     = word[isa_pkg::RS2_LSB +: core_cfg_pkg::REG_ADDR_W];
  imm     = {{(DATA_WIDTH - 16){word[15]}}, word[15:0]};
  defined = word[isa_pkg::OPC_LSB +: 4] <= 4'd9;  // Codes 10 to 15 are unused.
  a = model_read(rs1, ld_valid, ld_rd, ld_data);
  if ((op == isa_pkg::OP_ADDI) || (op == isa_pkg::OP_LUI)) begin
    b = imm;
  end else begin
    b = model_read(rs2, ld_valid, ld_rd, ld_data);
  end
  // Clock edge at the end of the cycle.
  if (pend_valid) begin
    shadow_regs[pend_rd] = pend_data;
  end
  if (ld_valid && !(pend_valid && (ld_rd == pend_rd))) begin
    shadow_regs[ld_rd] = ld_data;
  end
  pend_valid = valid_in && defined;
  pend_rd    = rd;
  pend_data  = op_result(op, a, b);
endtask

`endif

//--- verif/exec_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;

  localparam int DATA_WIDTH     = core_cfg_pkg::DATA_WIDTH_DEFAULT;
  localparam int RESET_CYCLES   = 16;
  localparam int RANDOM_CYCLES  = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 32 + RANDOM_CYCLES + 20;

  logic                                clk;
  logic                                reset;
  logic                                instr_valid;
  logic [isa_pkg::INSTR_W-1:0]         instr;
  logic                                load_valid;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] load_rd;
  logic [DATA_WIDTH-1:0]               load_data;
  logic                                wb_valid;
  logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [DATA_WIDTH-1:0]               wb_data;

  logic [31:0] lfsr_state  = 32'hf730_48ff;
  int          cycle_count = 0;

  `include "exec_core_model.svh"

  exec_core #(
    .DATA_WIDTH (DATA_WIDTH)
  ) exec_core_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .load_valid  (load_valid),
    .load_rd     (load_rd),
    .load_data   (load_data),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;  // Taps 32, 22, 2, 1.
    end
    return next;
  endfunction

  // One LFSR step per bit.
  function automatic logic [63:0] random_bits(input int count);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [isa_pkg::INSTR_W-1:0] encode_instr(
    input logic [3:0]                          opc,
    input logic [core_cfg_pkg::REG_ADDR_W-1:0] rd,
    input logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1,
    input logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2,
    input logic [15:0]                         imm
  );
    return {opc, rd, rs1, rs2, imm};
  endfunction

  task automatic check_rd(input logic [core_cfg_pkg::REG_ADDR_W-1:0] actual,
                          input logic [core_cfg_pkg::REG_ADDR_W-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error: wb_rd = 0x%h, expected 0x%h", actual, expected));
    end
  endtask

  task automatic check_data(input logic [DATA_WIDTH-1:0] actual,
                            input logic [DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error: wb_data = 0x%h, expected 0x%h", actual, expected));
    end
  endtask

  task automatic check_writeback();
    if (wb_valid !== pend_valid) begin
      if (pend_valid) begin
        fail_run($sformatf("Missing write-back for register %0d", pend_rd));
      end else begin
        fail_run("Unexpected write-back with no valid instruction in the previous cycle");
      end
    end
    if (pend_valid) begin
      check_rd(wb_rd, pend_rd);
      check_data(wb_data, pend_data);
    end
  endtask

  // Drives one cycle, checks the write-back and steps the model.
  task automatic run_cycle(input logic                                valid_in,
                           input logic [isa_pkg::INSTR_W-1:0]         word,
                           input logic                                ld_valid,
                           input logic [core_cfg_pkg::REG_ADDR_W-1:0] ld_rd,
                           input logic [DATA_WIDTH-1:0]               ld_data);
    @(posedge clk);
    instr_valid <= valid_in;
    instr       <= word;
    load_valid  <= ld_valid;
    load_rd     <= ld_rd;
    load_data   <= ld_data;
    @(negedge clk);  // Outputs settled mid-cycle.
    check_writeback();
    model_step(valid_in, word, ld_valid, ld_rd, ld_data);
  endtask

  task automatic random_cycle();
    logic                                valid_in;
    logic [3:0]                          opc;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2;
    logic [15:0]                         imm;
    logic                                ld_valid;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] ld_rd;
    logic [DATA_WIDTH-1:0]               ld_data;
    valid_in = random_bits(2) != 64'd0;
    opc      = 4'(random_bits(4));
    rd       = 4'(random_bits(4));
    // Lean on the previous rd to exercise forwarding.
    if (random_bits(2) == 64'd0) begin
      rs1 = pend_rd;
    end else begin
      rs1 = 4'(random_bits(4));
    end
    if (random_bits(2) == 64'd0) begin
      rs2 = pend_rd;
    end else begin
      rs2 = 4'(random_bits(4));
    end
    imm      = 16'(random_bits(16));
    ld_valid = random_bits(1) != 64'd0;
    if (random_bits(2) == 64'd0) begin
      ld_rd = pend_rd;  // Collides with this cycle's write-back.
    end else begin
      ld_rd = 4'(random_bits(4));
    end
    ld_data = DATA_WIDTH'(random_bits(DATA_WIDTH));
    run_cycle(valid_in, encode_instr(opc, rd, rs1, rs2, imm), ld_valid, ld_rd, ld_data);
  endtask

  initial begin
    reset       <= 1'b1;
    instr_valid <= 1'b1;  // Held valid through reset to test the clear.
    instr       <= encode_instr(isa_pkg::OP_LUI, '0, '0, '0, 16'hffff);
    load_valid  <= 1'b0;
    load_rd     <= '0;
    load_data   <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset       <= 1'b0;
    instr_valid <= 1'b0;
    @(negedge clk);
    if (wb_valid !== 1'b0) begin
      fail_run("Write-back seen for an instruction issued while reset was held");
    end

    // Define every register before any random reads.
    for (int i = 0; i < core_cfg_pkg::NUM_REGS; i++) begin
      run_cycle(1'b1, encode_instr(isa_pkg::OP_LUI, 4'(i), '0, '0, 16'(random_bits(16))),
                1'b0, '0, '0);
    end
    for (int i = 0; i < core_cfg_pkg::NUM_REGS; i++) begin
      run_cycle(1'b1, encode_instr(isa_pkg::OP_ADDI, 4'(i), 4'(i), '0, 16'(random_bits(16))),
                1'b0, '0, '0);
    end

    repeat (RANDOM_CYCLES) random_cycle();

    // Drain the last write-back.
    repeat (2) run_cycle(1'b0, '0, 1'b0, '0, '0);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_core.f
+incdir+verif
design/core_cfg_pkg.sv
design/isa_pkg.sv
design/issue_if.sv
design/instr_decode.sv
design/register_file.sv
design/execute_stage.sv
design/exec_core.sv
verif/exec_core_tb.sv

//--- Makefile
# Verilator build for the execute core and its testbench.

TB_TOP := exec_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f exec_core.f --top-module exec_core
	verilator --lint-only --timing -f exec_core.f --top-module $(TB_TOP)

# The simulator exits non-zero when the testbench stops with $fatal.
sim:
	verilator --binary --timing -f exec_core.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir
